//--- dma_wr.f
src/axi_pkg.sv
src/dma_pkg.sv
src/burst_if.sv
src/burst_queue.sv
src/dma_wr_engine.sv
src/wr_resp_tracker.sv
src/dma_wr_top.sv
tb/dma_wr_checker.sv
tb/tb_dma_wr.sv

//--- src/axi_pkg.sv
package axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Byte address
  localparam int unsigned AXI_ADDR_BITS  = 32;
  // Data bus, one 64 bit word per beat
  localparam int unsigned AXI_DATA_BITS  = 64;
  localparam int unsigned AXI_DATA_BYTES = 8;
  // awsize code, log2 of bytes per beat
  localparam int unsigned AXI_SIZE       = 3;
  // ID field, always driven zero
  localparam int unsigned AXI_ID_BITS    = 4;

  //////////////////////////////////////////////////////////////////////
  // Burst and cache codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] AXI_BURST_INCR    = 2'b01;
  // Bufferable, modifiable
  localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011;

  // Write response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

//--- src/burst_if.sv
// One record per issued burst
interface burst_if;

  // Record offered
  logic push;
  // Record accepted
  logic ready;
  // Final burst of its command
  logic last;
  // Command wants a completion report
  logic report;

  // Producer side
  modport src (
    output push, last, report,
    input  ready
  );

  // Consumer side
  modport dst (
    input  push, last, report,
    output ready
  );

endinterface

//--- src/burst_queue.sv
module burst_queue #(
  parameter int unsigned WIDTH = 4,
  parameter int unsigned DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,

  // Push side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,

  // Pop side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Entry storage
  logic [WIDTH-1:0] mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  logic push;
  logic pop;

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at DEPTH for any depth
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Producer must respect full
  a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
    in_valid |-> in_ready);

  // Consumer must respect empty
  a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
    out_ready |-> out_valid);

endmodule

//--- src/dma_pkg.sv
package dma_pkg;

  import axi_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Command fields
  //////////////////////////////////////////////////////////////////////

  // Byte length of one command
  localparam int unsigned LEN_BITS = 20;

  //////////////////////////////////////////////////////////////////////
  // Burst sizing
  //////////////////////////////////////////////////////////////////////

  // Max beats per INCR burst
  localparam int unsigned BURST_BEATS    = 16;
  // Beat count minus one fits here
  localparam int unsigned BURST_LEN_BITS = 4;
  // Address step from one burst to the next
  localparam int unsigned BURST_BYTES    = BURST_BEATS * AXI_DATA_BYTES;
  // Number of full bursts in a command
  localparam int unsigned XFER_CNT_BITS  = LEN_BITS - $clog2(BURST_BYTES);

  // Bursts between AW issue and B response
  localparam int unsigned MAX_OUTSTANDING = 4;

  // Address issue FSM
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    ISSUE = 2'd1,
    // Waiting for a free outstanding slot
    DRAIN = 2'd2
  } eng_state_e;

endpackage

//--- src/dma_wr_engine.sv
module dma_wr_engine
  import axi_pkg::*;
  import dma_pkg::*;
(
  input  logic                      aclk,
  input  logic                      aresetn,

  // Command port
  input  logic                      ctrl_valid,
  output logic                      ctrl_ready,
  input  logic [AXI_ADDR_BITS-1:0]  ctrl_addr,
  input  logic [LEN_BITS-1:0]       ctrl_len,
  input  logic                      ctrl_report,

  // AW channel
  output logic                      awvalid,
  input  logic                      awready,
  output logic [AXI_ADDR_BITS-1:0]  awaddr,
  output logic [AXI_ID_BITS-1:0]    awid,
  output logic [7:0]                awlen,
  output logic [2:0]                awsize,
  output logic [1:0]                awburst,
  output logic [3:0]                awcache,

  // W channel
  output logic [AXI_DATA_BITS-1:0]  wdata,
  output logic [AXI_DATA_BYTES-1:0] wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,

  // Input stream
  input  logic                      s_tvalid,
  output logic                      s_tready,
  input  logic [AXI_DATA_BITS-1:0]  s_tdata,
  input  logic [AXI_DATA_BYTES-1:0] s_tkeep,

  // Issued bursts towards the response side
  burst_if.src                      bq
);

  eng_state_e state;

  // Command split
  logic                      cmd_hs;
  logic [XFER_CNT_BITS-1:0]  cmd_full;
  logic [BURST_LEN_BITS-1:0] cmd_rem;

  // Latched command
  logic [AXI_ADDR_BITS-1:0]  addr_r;
  logic                      report_r;
  logic [XFER_CNT_BITS-1:0]  bursts_left;
  logic [BURST_LEN_BITS-1:0] part_len_r;
  logic                      has_part_r;

  // Address issue
  logic                      aw_hs;
  logic                      aw_final;
  logic                      slot_ok;
  logic [BURST_LEN_BITS-1:0] cur_len;
  logic                      len_in_ready;

  // Beat framing
  logic                      len_valid;
  logic [BURST_LEN_BITS-1:0] len_head;
  logic                      burst_load;
  logic                      burst_active;
  logic [BURST_LEN_BITS-1:0] beats_left;
  logic                      w_hs;

  //////////////////////////////////////////////////////////////////////
  // Command intake
  //////////////////////////////////////////////////////////////////////

  assign ctrl_ready = (state == IDLE);
  assign cmd_hs     = ctrl_valid & ctrl_ready;

  // Length in words: upper bits count full bursts, lower bits the tail
  assign cmd_full = ctrl_len[LEN_BITS-1 -: XFER_CNT_BITS];
  assign cmd_rem  = ctrl_len[AXI_SIZE +: BURST_LEN_BITS];

  always_ff @(posedge aclk) begin
    if (cmd_hs) begin
      addr_r     <= ctrl_addr;
      report_r   <= ctrl_report;
      // Bursts to go after the current one
      bursts_left <= (cmd_rem == '0) ? cmd_full - 1'b1 : cmd_full;
      part_len_r <= cmd_rem - 1'b1;
      has_part_r <= (cmd_rem != '0);
    end else if (aw_hs) begin
      addr_r      <= addr_r + BURST_BYTES;
      bursts_left <= bursts_left - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address issue FSM
  //////////////////////////////////////////////////////////////////////

  // Both queues need room, so outstanding bursts stay bounded
  assign slot_ok  = bq.ready & len_in_ready;
  assign aw_final = (bursts_left == '0);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_hs) state <= ISSUE;
        end
        ISSUE: begin
          if (aw_hs && aw_final) begin
            state <= IDLE;
          end else if (!slot_ok) begin
            state <= DRAIN;
          end
        end
        // Stall until a B frees a slot
        DRAIN: begin
          if (slot_ok) state <= ISSUE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Short tail only on the final burst
  assign cur_len = (aw_final && has_part_r) ? part_len_r
                                            : BURST_LEN_BITS'(BURST_BEATS - 1);

  // slot_ok only falls after a push, so valid never drops unaccepted
  assign awvalid = (state == ISSUE) & slot_ok;
  assign aw_hs   = awvalid & awready;
  assign awaddr  = addr_r;
  assign awlen   = {{(8 - BURST_LEN_BITS){1'b0}}, cur_len};
  assign awid    = '0;
  assign awsize  = 3'(AXI_SIZE);
  assign awburst = AXI_BURST_INCR;
  assign awcache = AXI_CACHE_DEFAULT;

  // Record per burst to the B side
  assign bq.push   = aw_hs;
  assign bq.last   = aw_final;
  assign bq.report = report_r;

  //////////////////////////////////////////////////////////////////////
  // W beat framing
  //////////////////////////////////////////////////////////////////////

  burst_queue #(
    .WIDTH (BURST_LEN_BITS),
    .DEPTH (MAX_OUTSTANDING)
  ) len_q (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (aw_hs),
    .in_ready  (len_in_ready),
    .in_data   (cur_len),
    .out_valid (len_valid),
    .out_ready (burst_load),
    .out_data  (len_head)
  );

  assign w_hs  = wvalid & wready;
  assign wlast = burst_active & (beats_left == '0);

  // Next burst starts when idle or right on the last beat
  assign burst_load = len_valid & (~burst_active | (w_hs & wlast));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      burst_active <= 1'b0;
      beats_left   <= '0;
    end else if (burst_load) begin
      burst_active <= 1'b1;
      beats_left   <= len_head;
    end else if (w_hs) begin
      if (wlast) begin
        burst_active <= 1'b0;
      end else begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  // Stream passes straight through inside a burst
  assign wvalid   = s_tvalid & burst_active;
  assign s_tready = wready & burst_active;
  assign wdata    = s_tdata;
  assign wstrb    = s_tkeep;

  // AW payload held while stalled
  a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

endmodule

//--- src/dma_wr_top.sv
module dma_wr_top
  import axi_pkg::*;
  import dma_pkg::*;
(
  input  logic                      aclk,
  input  logic                      aresetn,

  // Command and completion
  input  logic                      ctrl_valid,
  output logic                      ctrl_ready,
  input  logic [AXI_ADDR_BITS-1:0]  ctrl_addr,
  input  logic [LEN_BITS-1:0]       ctrl_len,
  input  logic                      ctrl_report,
  output logic                      done,
  output logic                      done_err,

  // AXI4 write master
  output logic                      awvalid,
  input  logic                      awready,
  output logic [AXI_ADDR_BITS-1:0]  awaddr,
  output logic [AXI_ID_BITS-1:0]    awid,
  output logic [7:0]                awlen,
  output logic [2:0]                awsize,
  output logic [1:0]                awburst,
  output logic [3:0]                awcache,
  output logic [AXI_DATA_BITS-1:0]  wdata,
  output logic [AXI_DATA_BYTES-1:0] wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,
  input  logic [AXI_ID_BITS-1:0]    bid,
  input  logic [1:0]                bresp,
  input  logic                      bvalid,
  output logic                      bready,

  // AXI4-Stream input
  input  logic                      s_tvalid,
  output logic                      s_tready,
  input  logic [AXI_DATA_BITS-1:0]  s_tdata,
  input  logic [AXI_DATA_BYTES-1:0] s_tkeep
);

  // Engine to queue, queue to tracker
  burst_if aw_bq ();
  burst_if b_bq ();

  logic [1:0] resp_in;
  logic [1:0] resp_out;

  dma_wr_engine u_engine (
    .aclk, .aresetn,
    .ctrl_valid, .ctrl_ready, .ctrl_addr, .ctrl_len, .ctrl_report,
    .awvalid, .awready, .awaddr, .awid, .awlen, .awsize, .awburst, .awcache,
    .wdata, .wstrb, .wlast, .wvalid, .wready,
    .s_tvalid, .s_tready, .s_tdata, .s_tkeep,
    .bq (aw_bq)
  );

  // Record packing, last above report
  assign resp_in     = {aw_bq.last, aw_bq.report};
  assign b_bq.last   = resp_out[1];
  assign b_bq.report = resp_out[0];

  // Bursts between AW and B
  burst_queue #(
    .WIDTH (2),
    .DEPTH (MAX_OUTSTANDING)
  ) resp_q (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (aw_bq.push),
    .in_ready  (aw_bq.ready),
    .in_data   (resp_in),
    .out_valid (b_bq.push),
    .out_ready (b_bq.ready),
    .out_data  (resp_out)
  );

  wr_resp_tracker u_tracker (
    .aclk, .aresetn,
    .bvalid, .bresp, .bready,
    .bq (b_bq),
    .done, .done_err
  );

  // Only ID zero is ever issued
  a_bid_zero: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid |-> (bid == '0));

endmodule

//--- src/wr_resp_tracker.sv
module wr_resp_tracker
  import axi_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,

  // B channel
  input  logic       bvalid,
  input  logic [1:0] bresp,
  output logic       bready,

  // Outstanding burst records, popped per response
  burst_if.dst       bq,

  // Completion report
  output logic       done,
  output logic       done_err
);

  logic b_hs;
  logic b_bad;
  // Sticky error for the command in progress
  logic err_r;

  //////////////////////////////////////////////////////////////////////
  // Response intake
  //////////////////////////////////////////////////////////////////////

  // Responses always accepted
  assign bready = 1'b1;
  assign b_hs   = bvalid & bready;

  // Each response retires the oldest burst
  assign bq.ready = b_hs;

  // EXOKAY counts as a failure too, no exclusive access here
  assign b_bad = (axi_resp_e'(bresp) != OKAY);

  //////////////////////////////////////////////////////////////////////
  // Error collection and done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      err_r    <= 1'b0;
      done     <= 1'b0;
      done_err <= 1'b0;
    end else begin
      // Single cycle pulse
      done <= 1'b0;
      if (b_hs) begin
        if (bq.last) begin
          // Command finished, fold in this last response
          done     <= bq.report;
          done_err <= err_r | b_bad;
          err_r    <= 1'b0;
        end else begin
          err_r <= err_r | b_bad;
        end
      end
    end
  end

  // Slave never answers a burst that was not issued
  a_b_outstanding: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid |-> bq.push);

endmodule

//--- tb/dma_wr_checker.sv
module dma_wr_checker
  import axi_pkg::*;
  import dma_pkg::*;
#(
  parameter logic [31:0] ERR_LO       = 32'h0000_8000,
  parameter logic [31:0] ERR_HI       = 32'h0000_9000,
  parameter int unsigned MEM_IDX_BITS = 14
) (
  input logic                     aclk,
  input logic                     aresetn,
  input logic                     ctrl_valid,
  input logic                     ctrl_ready,
  input logic [AXI_ADDR_BITS-1:0] ctrl_addr,
  input logic [LEN_BITS-1:0]      ctrl_len,
  input logic                     ctrl_report,
  input logic                     awvalid,
  input logic                     awready,
  input logic [AXI_ADDR_BITS-1:0] awaddr,
  input logic [AXI_ID_BITS-1:0]   awid,
  input logic [7:0]               awlen,
  input logic [2:0]               awsize,
  input logic [1:0]               awburst,
  input logic [3:0]               awcache,
  input logic                     wvalid,
  input logic                     wready,
  input logic                     wlast,
  input logic                     bvalid,
  input logic                     bready,
  input logic                     done,
  input logic                     done_err
);

  // Expected AW bursts in issue order
  logic [31:0] exp_addr_q [$];
  logic [7:0]  exp_len_q [$];
  string       exp_name_q [$];
  // Issued bursts still waiting for their beats
  logic [7:0]  w_len_q [$];
  string       w_name_q [$];
  // Commands waiting for their final response
  int          cmd_bursts_q [$];
  logic [31:0] cmd_addr_q [$];
  int          cmd_words_q [$];
  int          cmd_base_q [$];
  logic        cmd_rep_q [$];
  logic        cmd_err_q [$];
  string       cmd_name_q [$];

  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    cmd_pending = 0;
  int    word_base = 0;
  int    beat;
  int    b_seen;
  int    outstanding;
  int    n;
  logic  hit;
  logic  done_due;
  logic  err_due;
  logic [7:0] cur_len;
  string cur_name;
  string done_name;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Full bursts of BURST_BEATS first and the leftover words last
  function automatic int expand_cmd(input logic [31:0] addr, input int unsigned len);
    int unsigned words;
    int          cnt;
    words = len / AXI_DATA_BYTES;
    cnt   = 0;
    while (words > 0) begin
      exp_addr_q.push_back(addr + cnt * BURST_BYTES);
      if (words >= BURST_BEATS) begin
        exp_len_q.push_back(8'(BURST_BEATS - 1));
        words -= BURST_BEATS;
      end else begin
        exp_len_q.push_back(8'(words - 1));
        words = 0;
      end
      cnt++;
    end
    return cnt;
  endfunction

  // Stream word n holds the counter low and its inverse on top
  function automatic logic [63:0] expect_word(input logic [31:0] idx);
    return {~idx, idx};
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  // First bad word of the command or its last word when all match
  task automatic check_memory(input string name, input logic [31:0] addr,
                              input int words, input int base);
    int bad;
    bad = words - 1;
    for (int i = 0; i < words; i++) begin
      if (tb_dma_wr.mem[MEM_IDX_BITS'((addr >> AXI_SIZE) + i)] !== expect_word(base + i)) begin
        bad = i;
        break;
      end
    end
    check_value(name, "memory word", expect_word(base + bad),
                tb_dma_wr.mem[MEM_IDX_BITS'((addr >> AXI_SIZE) + bad)]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Port monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (!aresetn) begin
      done_due    = 1'b0;
      err_due     = 1'b0;
      outstanding = 0;
      beat        = 0;
      b_seen      = 0;
    end else begin
      // done is due one cycle after the final response
      if (done || done_due) begin
        check_value(done_name, "done", done_due, done);
        if (done && done_due) begin
          check_value(done_name, "done_err", err_due, done_err);
        end
      end
      done_due = 1'b0;

      if (ctrl_valid && ctrl_ready) begin
        n   = expand_cmd(ctrl_addr, ctrl_len);
        hit = 1'b0;
        for (int i = exp_addr_q.size() - n; i < exp_addr_q.size(); i++) begin
          hit |= (exp_addr_q[i] >= ERR_LO) && (exp_addr_q[i] < ERR_HI);
          exp_name_q.push_back(tb_dma_wr.test_name);
        end
        cmd_bursts_q.push_back(n);
        cmd_addr_q.push_back(ctrl_addr);
        cmd_words_q.push_back(ctrl_len / AXI_DATA_BYTES);
        cmd_base_q.push_back(word_base);
        cmd_rep_q.push_back(ctrl_report);
        cmd_err_q.push_back(hit);
        cmd_name_q.push_back(tb_dma_wr.test_name);
        word_base += ctrl_len / AXI_DATA_BYTES;
        cmd_pending++;
      end

      if (awvalid && awready) begin
        outstanding++;
        if (exp_addr_q.size() == 0) begin
          err_cnt++;
          $display("Unexpected AW burst at address %h, no command pending", awaddr);
        end else begin
          cur_name = exp_name_q.pop_front();
          cur_len  = exp_len_q.pop_front();
          check_value(cur_name, "awaddr", exp_addr_q.pop_front(), awaddr);
          check_value(cur_name, "awlen", cur_len, awlen);
          // Fixed AW fields of a single ID INCR master
          check_value(cur_name, "awid", '0, awid);
          check_value(cur_name, "awsize", $clog2(AXI_DATA_BYTES), awsize);
          check_value(cur_name, "awburst", AXI_BURST_INCR, awburst);
          check_value(cur_name, "awcache", AXI_CACHE_DEFAULT, awcache);
          w_len_q.push_back(cur_len);
          w_name_q.push_back(cur_name);
        end
      end

      // Beat count per burst with wlast only on the final one
      if (wvalid && wready) begin
        if (w_len_q.size() == 0) begin
          err_cnt++;
          $display("W beat sent outside any issued burst");
        end else begin
          check_value(w_name_q[0], "wlast", beat == w_len_q[0], wlast);
          if (beat == w_len_q[0]) begin
            void'(w_len_q.pop_front());
            void'(w_name_q.pop_front());
            beat = 0;
          end else begin
            beat++;
          end
        end
      end

      if (bvalid && bready) begin
        outstanding--;
        if (cmd_bursts_q.size() == 0) begin
          err_cnt++;
          $display("Write response arrived with no command pending");
        end else begin
          b_seen++;
          if (b_seen == cmd_bursts_q[0]) begin
            check_memory(cmd_name_q[0], cmd_addr_q[0], cmd_words_q[0], cmd_base_q[0]);
            done_due  = cmd_rep_q.pop_front();
            err_due   = cmd_err_q.pop_front();
            done_name = cmd_name_q.pop_front();
            void'(cmd_bursts_q.pop_front());
            void'(cmd_addr_q.pop_front());
            void'(cmd_words_q.pop_front());
            void'(cmd_base_q.pop_front());
            b_seen = 0;
            cmd_pending--;
          end
        end
      end

      // AW issued minus B seen
      if (outstanding > int'(MAX_OUTSTANDING) || outstanding < 0) begin
        err_cnt++;
        $display("Outstanding burst count out of range: %0d", outstanding);
      end
    end
  end

endmodule

//--- tb/tb_dma_wr.sv
module tb_dma_wr
  import axi_pkg::*;
  import dma_pkg::*;
();

  // Addresses in this window answer SLVERR
  localparam logic [31:0] ERR_LO       = 32'h0000_8000;
  localparam logic [31:0] ERR_HI       = 32'h0000_9000;
  localparam int unsigned MEM_IDX_BITS = 14;
  localparam int unsigned N_B2B        = 6;

  logic                      aclk;
  logic                      aresetn;
  logic                      ctrl_valid;
  logic                      ctrl_ready;
  logic [AXI_ADDR_BITS-1:0]  ctrl_addr;
  logic [LEN_BITS-1:0]       ctrl_len;
  logic                      ctrl_report;
  logic                      done;
  logic                      done_err;
  logic                      awvalid;
  logic                      awready;
  logic [AXI_ADDR_BITS-1:0]  awaddr;
  logic [AXI_ID_BITS-1:0]    awid;
  logic [7:0]                awlen;
  logic [2:0]                awsize;
  logic [1:0]                awburst;
  logic [3:0]                awcache;
  logic [AXI_DATA_BITS-1:0]  wdata;
  logic [AXI_DATA_BYTES-1:0] wstrb;
  logic                      wlast;
  logic                      wvalid;
  logic                      wready;
  logic [AXI_ID_BITS-1:0]    bid;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic                      s_tvalid;
  logic                      s_tready;
  logic [AXI_DATA_BITS-1:0]  s_tdata;
  logic [AXI_DATA_BYTES-1:0] s_tkeep;

  // Slave memory, one 64 bit word per entry
  logic [AXI_DATA_BITS-1:0] mem [0:(1 << MEM_IDX_BITS) - 1];
  logic [31:0]              aw_q [$];
  logic [1:0]               b_q [$];
  string                    test_name;
  int unsigned              b2b_len [N_B2B];
  logic                     b2b_rep [N_B2B];

  dma_wr_top DUT (.*);

  dma_wr_checker #(
    .ERR_LO       (ERR_LO),
    .ERR_HI       (ERR_HI),
    .MEM_IDX_BITS (MEM_IDX_BITS)
  ) chk (.*);

  always #20 aclk = ~aclk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Counter below, its inverse above
  function automatic logic [63:0] pattern_word(input logic [31:0] idx);
    return {~idx, idx};
  endfunction

  function automatic logic in_err_range(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  task automatic send_cmd(input string name, input logic [31:0] addr,
                          input int unsigned len, input logic rep);
    @(negedge aclk);
    test_name   = name;
    ctrl_valid  = 1'b1;
    ctrl_addr   = addr;
    ctrl_len    = LEN_BITS'(len);
    ctrl_report = rep;
    do @(posedge aclk); while (!ctrl_ready);
    @(negedge aclk);
    ctrl_valid = 1'b0;
  endtask

  // Every command retired, plus room for the done check
  task automatic wait_idle();
    wait (chk.cmd_pending == 0);
    repeat (2) @(negedge aclk);
  endtask

  task automatic watchdog(input int unsigned cycles);
    repeat (cycles) @(posedge aclk);
    $display("Timeout after %0d cycles, the DMA did not finish all commands", cycles);
    $display("Summary: %0d checks, %0d errors", chk.chk_cnt, chk.err_cnt);
    $display("test failed");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI slave and stream source
  //////////////////////////////////////////////////////////////////////

  task automatic serve_bus();
    logic [MEM_IDX_BITS-1:0] idx;
    int                      w_beat;
    int                      word_n;
    logic                    s_acc;
    logic                    b_acc;
    w_beat = 0;
    word_n = 0;
    wait (aresetn === 1'b1);
    forever begin
      // Sample handshakes of this edge
      @(posedge aclk);
      if (awvalid && awready) begin
        aw_q.push_back(awaddr);
      end
      if (wvalid && wready && aw_q.size() != 0) begin
        idx = MEM_IDX_BITS'((aw_q[0] >> AXI_SIZE) + w_beat);
        for (int b = 0; b < AXI_DATA_BYTES; b++) begin
          if (wstrb[b]) begin
            mem[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        w_beat++;
        // Response queued once the burst's last beat is in
        if (wlast) begin
          b_q.push_back(in_err_range(aw_q[0]) ? SLVERR : OKAY);
          void'(aw_q.pop_front());
          w_beat = 0;
        end
      end
      s_acc = s_tvalid && s_tready;
      b_acc = bvalid && bready;

      // Drive next values
      @(negedge aclk);
      awready = ($urandom_range(3) != 0);
      wready  = ($urandom_range(3) != 0);
      if (s_acc) begin
        word_n++;
      end
      // Stream word held until taken
      if (!s_tvalid || s_acc) begin
        s_tvalid = ($urandom_range(4) != 0);
        s_tdata  = pattern_word(word_n);
      end
      if (!bvalid || b_acc) begin
        if (b_q.size() != 0 && $urandom_range(1) == 1) begin
          bvalid = 1'b1;
          bresp  = b_q.pop_front();
        end else begin
          bvalid = 1'b0;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned total_bytes;
    void'($urandom(34546));
    aclk        = 1'b0;
    aresetn     = 1'b0;
    ctrl_valid  = 1'b0;
    ctrl_addr   = '0;
    ctrl_len    = '0;
    ctrl_report = 1'b0;
    awready     = 1'b0;
    wready      = 1'b0;
    bid         = '0;
    bresp       = '0;
    bvalid      = 1'b0;
    s_tvalid    = 1'b0;
    s_tdata     = pattern_word(0);
    s_tkeep     = '1;
    test_name   = "reset";

    // Lengths of the overlapping commands, whole words
    total_bytes = 512 + 296 + 256 + 200 + 64;
    for (int k = 0; k < N_B2B; k++) begin
      b2b_len[k] = $urandom_range(120, 1) * AXI_DATA_BYTES;
      b2b_rep[k] = $urandom_range(1);
      total_bytes += b2b_len[k];
    end

    fork
      serve_bus();
      watchdog(total_bytes / AXI_DATA_BYTES * 20 + 1000);
    join_none

    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Four full bursts
    send_cmd("full_bursts", 32'h0000_1000, 512, 1'b1);
    wait_idle();
    // Two full bursts and a 5 beat tail
    send_cmd("remainder", 32'h0000_2000, 296, 1'b1);
    wait_idle();
    // Next command overlaps the previous W and B traffic
    for (int k = 0; k < N_B2B; k++) begin
      send_cmd("back_to_back", 32'h0001_0000 + k * 32'h1000, b2b_len[k], b2b_rep[k]);
    end
    wait_idle();
    send_cmd("no_report", 32'h0000_3000, 256, 1'b0);
    wait_idle();
    send_cmd("slverr", ERR_LO, 200, 1'b1);
    wait_idle();
    send_cmd("clean_after_err", 32'h0000_4000, 64, 1'b1);
    wait_idle();

    repeat (4) @(negedge aclk);
    $display("Summary: %0d checks, %0d errors", chk.chk_cnt, chk.err_cnt);
    if (chk.err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
